// ==== common/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// datapath widths
`define XLEN        32
`define STRB_W      4

// data ram geometry and response delay
`define RAM_AW      8
`define RAM_LATENCY 2  // cycles from request seen to ready, 1 or more

// lsu opcode encodings from execute
`define LSU_OP_NONE  2'b00
`define LSU_OP_LOAD  2'b01
`define LSU_OP_STORE 2'b10

`endif

// ==== common/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  `include "lsu_macros.svh"

  typedef logic [`XLEN-1:0]   word_t;
  typedef logic [`XLEN-1:0]   addr_t;   // byte address
  typedef logic [`STRB_W-1:0] strb_t;
  typedef logic [2:0]         funct3_t; // riscv size/sign code

  typedef enum logic [1:0] {
    OP_NONE  = `LSU_OP_NONE,
    OP_LOAD  = `LSU_OP_LOAD,
    OP_STORE = `LSU_OP_STORE
  } lsu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD_PEND,
    ST_STORE_PEND
  } lsu_state_e;

  typedef enum logic {
    RAM_IDLE,
    RAM_BUSY
  } ram_state_e;

endpackage

`default_nettype wire

// ==== lsu/lsu_ctrl.sv ====
`default_nettype none

module lsu_ctrl import lsu_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire lsu_op_e lsu_op_i,
  input  wire          ifu_stall_i,
  input  wire word_t   src1_i,
  input  wire word_t   imm_i,
  input  wire          rsp_ready_i,
  output logic         req_valid_o,
  output logic         req_we_o,
  output addr_t        req_addr_o,
  output logic         mem_stall_o,
  output logic         rd_wen_o
);

  lsu_state_e state_q;
  lsu_state_e state_d;
  logic       pending;

  // issue only from idle, fetch side must not be stalled
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (!ifu_stall_i) begin
          if (lsu_op_i == OP_LOAD) begin
            state_d = ST_LOAD_PEND;
          end else if (lsu_op_i == OP_STORE) begin
            state_d = ST_STORE_PEND;
          end
        end
      end
      ST_LOAD_PEND,
      ST_STORE_PEND: begin
        if (rsp_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign pending = (state_q != ST_IDLE);

  // operands are held by execute while stalled
  assign req_addr_o  = src1_i + imm_i;
  assign req_valid_o = pending;
  assign req_we_o    = (state_q == ST_STORE_PEND);

  assign mem_stall_o = pending & ~rsp_ready_i;
  assign rd_wen_o    = pending & rsp_ready_i;  // also pulses on stores

endmodule

`default_nettype wire

// ==== lsu/lsu_align.sv ====
`default_nettype none

module lsu_align import lsu_pkg::*; (
  input  wire funct3_t    funct3_i,
  input  wire logic [1:0] addr_lo_i,
  input  wire word_t      src2_i,
  input  wire word_t      rdata_i,
  output word_t           wdata_o,
  output strb_t           strb_o,
  output word_t           rd_data_o
);

  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  // store side: replicate into every lane, strobe picks the lanes
  always_comb begin
    case (funct3_i)
      F3_B: begin
        wdata_o = {4{src2_i[7:0]}};
        strb_o  = strb_t'(4'b0001 << addr_lo_i);
      end
      F3_H: begin
        wdata_o = {2{src2_i[15:0]}};
        strb_o  = strb_t'(4'b0011 << {addr_lo_i[1], 1'b0});
      end
      F3_W: begin
        wdata_o = src2_i;
        strb_o  = 4'b1111;
      end
      default: begin
        wdata_o = src2_i;
        strb_o  = '0;  // no lanes written
      end
    endcase
  end

  // load side
  assign lane_b = rdata_i[{addr_lo_i, 3'b000} +: 8];
  assign lane_h = rdata_i[{addr_lo_i[1], 4'b0000} +: 16];

  always_comb begin
    case (funct3_i)
      F3_B:    rd_data_o = {{24{lane_b[7]}}, lane_b};
      F3_H:    rd_data_o = {{16{lane_h[15]}}, lane_h};
      F3_W:    rd_data_o = rdata_i;
      F3_BU:   rd_data_o = {24'd0, lane_b};
      F3_HU:   rd_data_o = {16'd0, lane_h};
      default: rd_data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/data_ram.sv ====
`default_nettype none

`include "lsu_macros.svh"

module data_ram import lsu_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        req_valid_i,
  input  wire        req_we_i,
  input  wire addr_t req_addr_i,
  input  wire word_t req_wdata_i,
  input  wire strb_t req_strb_i,
  output logic       rsp_ready_o,
  output word_t      rsp_rdata_o
);

  localparam int unsigned LAT = `RAM_LATENCY;
  localparam logic [7:0] CNT_INIT = (LAT > 1) ? 8'(LAT - 2) : 8'd0;

  word_t mem [0:(1 << `RAM_AW)-1];

  ram_state_e state_q;
  logic [7:0] cnt_q;

  // captured request, held while busy
  logic  cap_we;
  addr_t cap_addr;
  word_t cap_wdata;
  strb_t cap_strb;

  logic              accept;
  logic              fire;
  logic              op_we;
  logic [`RAM_AW-1:0] op_idx;
  word_t             op_wdata;
  strb_t             op_strb;

  // no new request during the ready cycle, valid is still up then
  assign accept = (state_q == RAM_IDLE) & req_valid_i & ~rsp_ready_o;
  assign fire   = (accept & (LAT == 1)) | ((state_q == RAM_BUSY) & (cnt_q == 8'd0));

  // latency 1 serves straight from the request lines
  assign op_we    = (state_q == RAM_IDLE) ? req_we_i : cap_we;
  assign op_idx   = (state_q == RAM_IDLE) ? req_addr_i[`RAM_AW+1:2] : cap_addr[`RAM_AW+1:2];
  assign op_wdata = (state_q == RAM_IDLE) ? req_wdata_i : cap_wdata;
  assign op_strb  = (state_q == RAM_IDLE) ? req_strb_i : cap_strb;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= RAM_IDLE;
      cnt_q       <= '0;
      rsp_ready_o <= 1'b0;
    end else begin
      rsp_ready_o <= fire;
      if (accept && LAT > 1) begin
        state_q <= RAM_BUSY;
        cnt_q   <= CNT_INIT;
      end else if (state_q == RAM_BUSY) begin
        if (cnt_q == 8'd0) begin
          state_q <= RAM_IDLE;
        end else begin
          cnt_q <= cnt_q - 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cap_we    <= req_we_i;
      cap_addr  <= req_addr_i;
      cap_wdata <= req_wdata_i;
      cap_strb  <= req_strb_i;
    end
  end

  // array access on the last latency cycle
  always_ff @(posedge clk) begin
    if (fire) begin
      if (op_we) begin
        for (int i = 0; i < `STRB_W; i++) begin
          if (op_strb[i]) begin
            mem[op_idx][8*i +: 8] <= op_wdata[8*i +: 8];
          end
        end
      end else begin
        rsp_rdata_o <= mem[op_idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire lsu_op_e lsu_op_i,
  input  wire funct3_t funct3_i,
  input  wire word_t   src1_i,
  input  wire word_t   src2_i,
  input  wire word_t   imm_i,
  input  wire          ifu_stall_i,
  output logic         mem_stall_o,
  output logic         rd_wen_o,
  output word_t        rd_data_o
);

  logic  req_valid;
  logic  req_we;
  addr_t req_addr;
  word_t req_wdata;
  strb_t req_strb;
  logic  rsp_ready;
  word_t rsp_rdata;

  lsu_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .lsu_op_i    (lsu_op_i),
    .ifu_stall_i (ifu_stall_i),
    .src1_i      (src1_i),
    .imm_i       (imm_i),
    .rsp_ready_i (rsp_ready),
    .req_valid_o (req_valid),
    .req_we_o    (req_we),
    .req_addr_o  (req_addr),
    .mem_stall_o (mem_stall_o),
    .rd_wen_o    (rd_wen_o)
  );

  lsu_align u_align (
    .funct3_i  (funct3_i),
    .addr_lo_i (req_addr[1:0]),
    .src2_i    (src2_i),
    .rdata_i   (rsp_rdata),
    .wdata_o   (req_wdata),
    .strb_o    (req_strb),
    .rd_data_o (rd_data_o)
  );

  data_ram u_ram (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_we_i    (req_we),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .req_strb_i  (req_strb),
    .rsp_ready_o (rsp_ready),
    .rsp_rdata_o (rsp_rdata)
  );

endmodule

`default_nettype wire

// ==== bench/lsu_asserts.sv ====
`default_nettype none

module lsu_asserts (
  input wire clk,
  input wire rst_n,
  input wire req_valid_i,
  input wire rsp_ready_i,
  input wire mem_stall_i,
  input wire rd_wen_i
);

  // write-back strobe is a single pulse
  a_wen_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    rd_wen_i |=> !rd_wen_i)
    else $error("rd_wen_o high for more than one cycle");

  // stall hands over to the write-back pulse in one cycle
  a_stall_vs_wen: assert property (@(posedge clk) disable iff (!rst_n)
    rd_wen_i |-> (!mem_stall_i && $past(mem_stall_i)))
    else $error("mem_stall_o did not hand over to rd_wen_o");

  // request level held until the ram answers
  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid_i && !rsp_ready_i) |=> req_valid_i)
    else $error("req_valid dropped before rsp_ready");

  a_reset_low: assert property (@(posedge clk)
    !rst_n |=> (!req_valid_i && !mem_stall_i && !rd_wen_i))
    else $error("outputs not low after reset");

endmodule

bind lsu_top lsu_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .req_valid_i (req_valid),
  .rsp_ready_i (rsp_ready),
  .mem_stall_i (mem_stall_o),
  .rd_wen_i    (rd_wen_o)
);

`default_nettype wire

// ==== bench/lsu_tb.sv ====
`default_nettype none

`include "lsu_macros.svh"

module lsu_tb import lsu_pkg::*; ();

  localparam int LAT        = `RAM_LATENCY;
  localparam int NUM_VEC    = 34;
  localparam int VEC_W      = 7;  // words per vector line
  localparam int RST_CYCLES = 2;

  logic    clk;
  logic    rst_n;
  lsu_op_e lsu_op;
  funct3_t funct3;
  word_t   src1;
  word_t   src2;
  word_t   imm;
  logic    ifu_stall;
  logic    mem_stall;
  logic    rd_wen;
  word_t   rd_data;

  logic [31:0] vec_mem [0:NUM_VEC*VEC_W-1];
  int          err_cnt = 0;
  int          cyc_cnt = 0;
  int          cyc_limit;

  lsu_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .lsu_op_i    (lsu_op),
    .funct3_i    (funct3),
    .src1_i      (src1),
    .src2_i      (src2),
    .imm_i       (imm),
    .ifu_stall_i (ifu_stall),
    .mem_stall_o (mem_stall),
    .rd_wen_o    (rd_wen),
    .rd_data_o   (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_limit > 0 && cyc_cnt >= cyc_limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cyc_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_word(input string name, input word_t act, input word_t exp_val);
    if (act !== exp_val) begin
      $display("Fail %s: expected %08h, got %08h", name, exp_val, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp_val);
    if (act !== exp_val) begin
      $display("Fail %s: expected %0h, got %0h", name, exp_val, act);
      err_cnt++;
    end
  endtask

  task automatic run_vector(input int idx);
    logic [31:0] op_w;
    logic [31:0] f3_w;
    logic [31:0] hold;
    word_t       exp_data;
    int          cycles;
    int          errs_before;
    logic        seen;
    op_w        = vec_mem[idx*VEC_W];
    f3_w        = vec_mem[idx*VEC_W+1];
    hold        = vec_mem[idx*VEC_W+5];
    exp_data    = vec_mem[idx*VEC_W+6];
    errs_before = err_cnt;
    @(posedge clk);
    lsu_op    <= lsu_op_e'(op_w[1:0]);
    funct3    <= f3_w[2:0];
    src1      <= vec_mem[idx*VEC_W+2];
    src2      <= vec_mem[idx*VEC_W+3];
    imm       <= vec_mem[idx*VEC_W+4];
    ifu_stall <= (hold != 0);
    repeat (hold) begin  // fetch side stalled, nothing may issue
      @(negedge clk);
      check_bit("mem_stall_o", mem_stall, 1'b0);
      check_bit("rd_wen_o", rd_wen, 1'b0);
      @(posedge clk);
    end
    ifu_stall <= 1'b0;
    if (op_w[1:0] == `LSU_OP_NONE) begin
      repeat (LAT + 2) begin
        @(posedge clk);
        @(negedge clk);
        check_bit("mem_stall_o", mem_stall, 1'b0);
        check_bit("rd_wen_o", rd_wen, 1'b0);
      end
    end else begin
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < LAT + 3) begin
        @(posedge clk);
        cycles++;
        @(negedge clk);
        if (rd_wen) begin
          seen = 1'b1;
        end else if (cycles <= LAT) begin
          check_bit("mem_stall_o", mem_stall, 1'b1);
        end
      end
      if (!seen) begin
        $display("vector %0d: no rd_wen_o pulse within %0d cycles", idx, cycles);
        err_cnt++;
      end else begin
        check_word("latency", word_t'(cycles), word_t'(1 + LAT));
        check_bit("mem_stall_o", mem_stall, 1'b0);
        if (op_w[1:0] == `LSU_OP_LOAD) begin
          check_word("rd_data_o", rd_data, exp_data);
        end
      end
    end
    if (err_cnt == errs_before) begin
      $display("vector %0d op %0d funct3 %0d: ok", idx, op_w[1:0], f3_w[2:0]);
    end else begin
      $display("vector %0d op %0d funct3 %0d: failed", idx, op_w[1:0], f3_w[2:0]);
    end
  endtask

  initial begin
    int max_hold;
    rst_n     = 1'b0;
    lsu_op    = OP_NONE;
    funct3    = '0;
    src1      = '0;
    src2      = '0;
    imm       = '0;
    ifu_stall = 1'b0;
    $readmemh("bench/lsu_vectors.hex", vec_mem);
    max_hold = 0;
    for (int i = 0; i < NUM_VEC; i++) begin
      if (int'(vec_mem[i*VEC_W+5]) > max_hold) begin
        max_hold = int'(vec_mem[i*VEC_W+5]);
      end
    end
    cyc_limit = NUM_VEC * (1 + LAT + max_hold + 4) + RST_CYCLES;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    for (int v = 0; v < NUM_VEC; v++) begin
      run_vector(v);
    end
    $display("%0d vectors run, %0d errors", NUM_VEC, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/lsu_vectors.hex ====
// columns: op funct3 src1 src2 imm hold expected_rd_data
// op 0 none, 1 load, 2 store; hold is ifu_stall cycles before release
0 0 00000000 00000000 00000000 0 00000000
2 2 00000100 deadbeef 00000000 0 00000000
1 2 00000100 00000000 00000000 0 deadbeef
2 2 00000104 11223344 00000000 0 00000000
2 0 00000104 ffffffaa 00000000 0 00000000
2 0 00000104 000000bb 00000001 0 00000000
1 2 00000104 00000000 00000000 0 1122bbaa
2 0 00000106 123456cc 00000000 0 00000000
2 0 00000100 000000dd 00000007 0 00000000
1 2 00000104 00000000 00000000 0 ddccbbaa
2 2 00000108 55667788 00000000 0 00000000
2 1 00000108 abcdeeff 00000000 0 00000000
1 2 00000108 00000000 00000000 0 5566eeff
2 1 00000108 00001234 00000002 0 00000000
1 2 00000108 00000000 00000000 0 1234eeff
2 2 0000010c 81f27a93 00000000 0 00000000
1 0 0000010c 00000000 00000000 0 ffffff93
1 0 0000010c 00000000 00000001 0 0000007a
1 0 0000010e 00000000 00000000 0 fffffff2
1 0 0000010c 00000000 00000003 0 ffffff81
1 4 0000010c 00000000 00000000 0 00000093
1 4 0000010d 00000000 00000000 0 0000007a
1 4 0000010e 00000000 00000000 0 000000f2
1 4 0000010f 00000000 00000000 0 00000081
1 1 0000010c 00000000 00000000 0 00007a93
1 1 0000010e 00000000 00000000 0 ffff81f2
1 5 0000010c 00000000 00000000 0 00007a93
1 5 0000010c 00000000 00000002 0 000081f2
2 2 00000110 cafef00d 00000000 3 00000000
1 2 00000110 00000000 00000000 5 cafef00d
1 2 00000118 00000000 fffffff4 0 81f27a93
2 2 00000200 0badc0de ffffff1c 0 00000000
1 2 0000011c 00000000 00000000 0 0badc0de
0 0 00000000 00000000 00000000 2 00000000

// ==== files.f ====
+incdir+common
common/lsu_pkg.sv
lsu/lsu_ctrl.sv
lsu/lsu_align.sv
hw/data_ram.sv
hw/lsu_top.sv
bench/lsu_asserts.sv
bench/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lsu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
